/* src/rename_config.svh */
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural register file
`define NUM_AREG 32
`define AREG_W 5

// reorder buffer, ids double as physical result names
`define ROB_DEPTH 64
`define ROB_W 6

`define XLEN 32

// leaves room for the bundles still in flight when availability drops
`define ROB_HIGH_WATER 60

`endif

/* src/rename_pkg.sv */
`include "rename_config.svh"

package rename_pkg;

    typedef logic [`AREG_W-1:0] areg_t;
    typedef logic [`ROB_W-1:0]  rob_id_t;
    typedef logic [`XLEN-1:0]   data_t;

    // check flips on every rename of the register
    typedef struct packed {
        logic    check;
        rob_id_t rob_id;
    } rat_entry_t;

    // src_areg[1:0] belong to slot0
    typedef struct packed {
        data_t        pc;
        logic [1:0]   slot_valid;
        areg_t [3:0]  src_areg;
        logic [3:0]   src_need;
        areg_t [1:0]  dst_areg;
        logic [1:0]   dst_we;
        logic [1:0]   use_imm;
        data_t [1:0]  imm;
    } decode_bundle_t;

    typedef struct packed {
        data_t          pc;
        logic [1:0]     slot_valid;
        areg_t [1:0]    dst_areg;
        rob_id_t [1:0]  dst_rob;
        logic [1:0]     dst_check;
        rob_id_t [3:0]  src_rob;
        data_t [3:0]    src_data;
        logic [3:0]     src_ready;
        logic [1:0]     use_imm;
        data_t [1:0]    imm;
    } dispatch_bundle_t;

    typedef struct packed {
        rob_id_t rob_id;
        areg_t   areg;
        logic    we;
        logic    check;
        data_t   data;
    } retire_t;

endpackage

/* src/spec_rat.sv */
`timescale 1ns/1ns
`include "rename_config.svh"

module spec_rat (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          flush_i,
    input  rename_pkg::areg_t [3:0]       raddr_i,
    output rename_pkg::rat_entry_t [3:0]  rdata_o,
    input  rename_pkg::areg_t [1:0]       waddr_i,
    input  logic [1:0]                    we_i,
    input  rename_pkg::rat_entry_t [1:0]  wdata_i
);

    rename_pkg::rat_entry_t [`NUM_AREG-1:0] map_q;

    // reads see the table as of the last edge
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            rdata_o[r] = map_q[raddr_i[r]];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            map_q <= '0;
        end else if (flush_i) begin
            map_q <= '0;
        end else begin
            // later port overrides on the same register
            for (int w = 0; w < 2; w++) begin
                if (we_i[w]) begin
                    map_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    // register 0 must keep its reset entry so its sources always read ready
    no_zero_write_a: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !(we_i[0] && waddr_i[0] == '0) && !(we_i[1] && waddr_i[1] == '0)
    );

endmodule

/* src/commit_rat.sv */
`timescale 1ns/1ns
`include "rename_config.svh"

module commit_rat (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          flush_i,
    input  rename_pkg::areg_t [5:0]       raddr_i,
    output rename_pkg::rat_entry_t [5:0]  rdata_o,
    input  logic [1:0]                    retire_valid_i,
    input  rename_pkg::retire_t [1:0]     retire_i
);

    rename_pkg::rat_entry_t [`NUM_AREG-1:0] map_q;
    logic [1:0]                             wr_en;
    rename_pkg::rat_entry_t [1:0]           wr_data;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wr_en[w] = retire_valid_i[w] && retire_i[w].we
                       && (retire_i[w].areg != '0);
            wr_data[w].check  = retire_i[w].check;
            wr_data[w].rob_id = retire_i[w].rob_id;
        end
    end

    // same-cycle retire is forwarded, port 1 checked last so it wins
    always_comb begin
        for (int r = 0; r < 6; r++) begin
            rdata_o[r] = map_q[raddr_i[r]];
            for (int w = 0; w < 2; w++) begin
                if (wr_en[w] && retire_i[w].areg == raddr_i[r]) begin
                    rdata_o[r] = wr_data[w];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            map_q <= '0;
        end else if (flush_i) begin
            map_q <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (wr_en[w]) begin
                    map_q[retire_i[w].areg] <= wr_data[w];
                end
            end
        end
    end

endmodule

/* src/arf.sv */
`timescale 1ns/1ns
`include "rename_config.svh"

module arf (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       flush_i,
    input  rename_pkg::areg_t [3:0]    raddr_i,
    output rename_pkg::data_t [3:0]    rdata_o,
    input  logic [1:0]                 retire_valid_i,
    input  rename_pkg::retire_t [1:0]  retire_i
);

    rename_pkg::data_t [`NUM_AREG-1:0] regs_q;
    logic [1:0]                        wr_en;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wr_en[w] = retire_valid_i[w] && retire_i[w].we
                       && (retire_i[w].areg != '0);
        end
    end

    always_comb begin
        for (int r = 0; r < 4; r++) begin
            rdata_o[r] = regs_q[raddr_i[r]];
            for (int w = 0; w < 2; w++) begin
                if (wr_en[w] && retire_i[w].areg == raddr_i[r]) begin
                    rdata_o[r] = retire_i[w].data;
                end
            end
            // hardwired zero
            if (raddr_i[r] == '0) begin
                rdata_o[r] = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs_q <= '0;
        end else if (flush_i) begin
            regs_q <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (wr_en[w]) begin
                    regs_q[retire_i[w].areg] <= retire_i[w].data;
                end
            end
        end
    end

endmodule

/* src/rename_ctrl.sv */
`timescale 1ns/1ns
`include "rename_config.svh"

module rename_ctrl (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          flush_i,
    input  logic                          in_valid_i,
    input  rename_pkg::decode_bundle_t    in_bundle_i,
    output logic                          in_ready_o,
    output logic                          out_valid_o,
    output rename_pkg::dispatch_bundle_t  out_bundle_o,
    input  logic                          out_ready_i,
    input  logic [1:0]                    retire_valid_i,
    output rename_pkg::areg_t [3:0]       spec_raddr_o,
    input  rename_pkg::rat_entry_t [3:0]  spec_rdata_i,
    output rename_pkg::areg_t [1:0]       spec_waddr_o,
    output logic [1:0]                    spec_we_o,
    output rename_pkg::rat_entry_t [1:0]  spec_wdata_o,
    output rename_pkg::areg_t [5:0]       commit_raddr_o,
    input  rename_pkg::rat_entry_t [5:0]  commit_rdata_i,
    input  rename_pkg::data_t [3:0]       arf_rdata_i
);

    rename_pkg::rob_id_t           head_q;
    logic [`ROB_W:0]               occ_q;
    logic                          avail_q;
    logic                          out_valid_q;
    rename_pkg::dispatch_bundle_t  out_q;
    logic                          accept;
    logic [1:0]                    n_issue;
    logic [1:0]                    n_retire;
    logic [1:0]                    dst_wr;
    rename_pkg::rob_id_t [1:0]     dst_rob;
    rename_pkg::dispatch_bundle_t  next_bundle;

    assign in_ready_o = avail_q && !flush_i && (!out_valid_q || out_ready_i);
    assign accept     = in_valid_i && in_ready_o;
    assign n_issue    = accept ? 2'(in_bundle_i.slot_valid[0]) + 2'(in_bundle_i.slot_valid[1])
                               : 2'd0;
    assign n_retire   = 2'(retire_valid_i[0]) + 2'(retire_valid_i[1]);

    // slot1 takes the next id only when slot0 used the head
    assign dst_rob[0] = head_q;
    assign dst_rob[1] = in_bundle_i.slot_valid[0] ? head_q + rename_pkg::rob_id_t'(1) : head_q;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            dst_wr[i] = in_bundle_i.slot_valid[i] && in_bundle_i.dst_we[i]
                        && (in_bundle_i.dst_areg[i] != '0);
            spec_wdata_o[i].check  = ~commit_rdata_i[4 + i].check;
            spec_wdata_o[i].rob_id = dst_rob[i];
        end
    end

    assign spec_we_o      = dst_wr & {2{accept}};
    assign spec_waddr_o   = in_bundle_i.dst_areg;
    assign spec_raddr_o   = in_bundle_i.src_areg;
    assign commit_raddr_o = {in_bundle_i.dst_areg, in_bundle_i.src_areg};

    always_comb begin
        next_bundle.pc         = in_bundle_i.pc;
        next_bundle.slot_valid = in_bundle_i.slot_valid;
        next_bundle.dst_areg   = in_bundle_i.dst_areg;
        next_bundle.dst_rob    = dst_rob;
        next_bundle.dst_check  = {spec_wdata_o[1].check, spec_wdata_o[0].check};
        next_bundle.use_imm    = in_bundle_i.use_imm;
        next_bundle.imm        = in_bundle_i.imm;
        for (int j = 0; j < 4; j++) begin
            next_bundle.src_rob[j]   = spec_rdata_i[j].rob_id;
            next_bundle.src_data[j]  = arf_rdata_i[j];
            next_bundle.src_ready[j] = !in_bundle_i.src_need[j]
                || (spec_rdata_i[j].check == commit_rdata_i[j].check);
        end
        // slot1 sources produced by slot0 of this bundle
        for (int j = 2; j < 4; j++) begin
            if (dst_wr[0] && in_bundle_i.src_areg[j] == in_bundle_i.dst_areg[0]) begin
                next_bundle.src_rob[j]   = dst_rob[0];
                next_bundle.src_ready[j] = !in_bundle_i.src_need[j];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q      <= '0;
            occ_q       <= '0;
            avail_q     <= 1'b1;
            out_valid_q <= 1'b0;
        end else if (flush_i) begin
            head_q      <= '0;
            occ_q       <= '0;
            avail_q     <= 1'b1;
            out_valid_q <= 1'b0;
        end else begin
            head_q  <= head_q + rename_pkg::rob_id_t'(n_issue);
            occ_q   <= occ_q + (`ROB_W + 1)'(n_issue) - (`ROB_W + 1)'(n_retire);
            // one edge behind the count, hence the margin below the depth
            avail_q <= (occ_q <= `ROB_HIGH_WATER);
            if (accept) begin
                out_valid_q <= 1'b1;
            end else if (out_ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_q <= next_bundle;
        end
    end

    assign out_valid_o  = out_valid_q;
    assign out_bundle_o = out_q;

    occ_bound_a: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        occ_q <= `ROB_DEPTH
    );

    out_hold_a: assert property (
        @(posedge clk) disable iff (!arst_n_i || flush_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_bundle_o)
    );

endmodule

/* src/rename_unit.sv */
`timescale 1ns/1ns

module rename_unit (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          in_valid_i,
    input  rename_pkg::decode_bundle_t    in_bundle_i,
    output logic                          in_ready_o,
    output logic                          out_valid_o,
    output rename_pkg::dispatch_bundle_t  out_bundle_o,
    input  logic                          out_ready_i,
    input  logic [1:0]                    retire_valid_i,
    input  rename_pkg::retire_t [1:0]     retire_i,
    input  logic                          flush_i
);

    rename_pkg::areg_t [3:0]       src_raddr;
    rename_pkg::rat_entry_t [3:0]  spec_rdata;
    rename_pkg::areg_t [1:0]       spec_waddr;
    logic [1:0]                    spec_we;
    rename_pkg::rat_entry_t [1:0]  spec_wdata;
    rename_pkg::areg_t [5:0]       commit_raddr;
    rename_pkg::rat_entry_t [5:0]  commit_rdata;
    rename_pkg::data_t [3:0]       arf_rdata;

    rename_ctrl rename_ctrl_i (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .in_valid_i     (in_valid_i),
        .in_bundle_i    (in_bundle_i),
        .in_ready_o     (in_ready_o),
        .out_valid_o    (out_valid_o),
        .out_bundle_o   (out_bundle_o),
        .out_ready_i    (out_ready_i),
        .retire_valid_i (retire_valid_i),
        .spec_raddr_o   (src_raddr),
        .spec_rdata_i   (spec_rdata),
        .spec_waddr_o   (spec_waddr),
        .spec_we_o      (spec_we),
        .spec_wdata_o   (spec_wdata),
        .commit_raddr_o (commit_raddr),
        .commit_rdata_i (commit_rdata),
        .arf_rdata_i    (arf_rdata)
    );

    spec_rat spec_rat_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .raddr_i  (src_raddr),
        .rdata_o  (spec_rdata),
        .waddr_i  (spec_waddr),
        .we_i     (spec_we),
        .wdata_i  (spec_wdata)
    );

    // retire port feeds both committed structures directly
    commit_rat commit_rat_i (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .raddr_i        (commit_raddr),
        .rdata_o        (commit_rdata),
        .retire_valid_i (retire_valid_i),
        .retire_i       (retire_i)
    );

    arf arf_i (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .raddr_i        (src_raddr),
        .rdata_o        (arf_rdata),
        .retire_valid_i (retire_valid_i),
        .retire_i       (retire_i)
    );

endmodule

/* verification/rename_unit_tb.sv */
`timescale 1ns/1ns
`include "rename_config.svh"

module rename_unit_tb;

    localparam int TEST_CYCLES = 415;
    localparam int CYCLE_LIMIT = TEST_CYCLES * 3 / 2;

    logic                          clk;
    logic                          arst_n_i;
    logic                          in_valid_i;
    rename_pkg::decode_bundle_t    in_bundle_i;
    logic                          in_ready_o;
    logic                          out_valid_o;
    rename_pkg::dispatch_bundle_t  out_bundle_o;
    logic                          out_ready_i;
    logic [1:0]                    retire_valid_i;
    rename_pkg::retire_t [1:0]     retire_i;
    logic                          flush_i;

    // reference model state
    rename_pkg::rat_entry_t        spec_m [`NUM_AREG];
    rename_pkg::rat_entry_t        commit_m [`NUM_AREG];
    rename_pkg::data_t             regs_m [`NUM_AREG];
    rename_pkg::rob_id_t           head_m;
    int                            occ_m;
    logic                          avail_m;
    logic                          valid_m;
    rename_pkg::retire_t           issued_q [$];
    rename_pkg::dispatch_bundle_t  exp_q [$];

    logic [15:0]                   lfsr_q = 16'd35;
    int                            cycle_cnt = 0;
    logic                          stall_q = 1'b0;
    rename_pkg::dispatch_bundle_t  held_q;

    rename_unit rename_unit_i (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .in_valid_i     (in_valid_i),
        .in_bundle_i    (in_bundle_i),
        .in_ready_o     (in_ready_o),
        .out_valid_o    (out_valid_o),
        .out_bundle_o   (out_bundle_o),
        .out_ready_i    (out_ready_i),
        .retire_valid_i (retire_valid_i),
        .retire_i       (retire_i),
        .flush_i        (flush_i)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout, the run went past %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

    task automatic check_equal(input string what, input logic [511:0] got,
                               input logic [511:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    // galois form with taps 16,14,13,11
    function automatic logic [15:0] next_lfsr(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = next_lfsr(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // small register range so hazards are frequent
    function automatic rename_pkg::decode_bundle_t random_bundle();
        rename_pkg::decode_bundle_t b;
        b.pc = take_bits(16);
        b.slot_valid = 2'(take_bits(2));
        for (int j = 0; j < 4; j++) begin
            b.src_areg[j] = rename_pkg::areg_t'(take_bits(3));
        end
        b.src_need = 4'(take_bits(4));
        for (int i = 0; i < 2; i++) begin
            b.dst_areg[i] = rename_pkg::areg_t'(take_bits(3));
            b.imm[i] = take_bits(12);
        end
        b.dst_we = 2'(take_bits(2));
        b.use_imm = 2'(take_bits(2));
        return b;
    endfunction

    function automatic rename_pkg::dispatch_bundle_t predict(input rename_pkg::decode_bundle_t b);
        rename_pkg::dispatch_bundle_t d;
        rename_pkg::areg_t            a;
        logic                         wr0;
        d = '0;
        d.pc = b.pc;
        d.slot_valid = b.slot_valid;
        d.dst_areg = b.dst_areg;
        d.use_imm = b.use_imm;
        d.imm = b.imm;
        d.dst_rob[0] = head_m;
        d.dst_rob[1] = b.slot_valid[0] ? head_m + rename_pkg::rob_id_t'(1) : head_m;
        wr0 = b.slot_valid[0] && b.dst_we[0] && b.dst_areg[0] != '0;
        for (int i = 0; i < 2; i++) begin
            d.dst_check[i] = ~commit_m[b.dst_areg[i]].check;
        end
        for (int j = 0; j < 4; j++) begin
            a = b.src_areg[j];
            d.src_rob[j] = spec_m[a].rob_id;
            d.src_data[j] = regs_m[a];
            d.src_ready[j] = !b.src_need[j] || spec_m[a].check == commit_m[a].check;
            // slot1 reading slot0's destination
            if (j >= 2 && wr0 && a == b.dst_areg[0]) begin
                d.src_rob[j] = d.dst_rob[0];
                d.src_ready[j] = !b.src_need[j];
            end
        end
        return d;
    endfunction

    task automatic reset_model();
        spec_m = '{default: '0};
        commit_m = '{default: '0};
        regs_m = '{default: '0};
        head_m = '0;
        occ_m = 0;
        avail_m = 1'b1;
        valid_m = 1'b0;
        issued_q.delete();
        exp_q.delete();
    endtask

    // evaluated late in the cycle so the state becomes what the next edge produces
    task automatic update_model();
        logic                         accept;
        logic                         wr;
        int                           n_iss;
        int                           n_ret;
        rename_pkg::dispatch_bundle_t d;
        check_equal("in_ready_o", in_ready_o,
                    avail_m && !flush_i && (!valid_m || out_ready_i));
        check_equal("out_valid_o", out_valid_o, valid_m);
        if (flush_i) begin
            reset_model();
        end else begin
            // retires first since their writes are forwarded to this bundle
            for (int k = 0; k < 2; k++) begin
                if (retire_valid_i[k] && retire_i[k].we && retire_i[k].areg != '0) begin
                    commit_m[retire_i[k].areg] = '{check: retire_i[k].check,
                                                   rob_id: retire_i[k].rob_id};
                    regs_m[retire_i[k].areg] = retire_i[k].data;
                end
            end
            accept = in_valid_i && in_ready_o;
            n_iss = 0;
            if (accept) begin
                d = predict(in_bundle_i);
                exp_q.push_back(d);
                for (int i = 0; i < 2; i++) begin
                    if (in_bundle_i.slot_valid[i]) begin
                        n_iss++;
                        wr = in_bundle_i.dst_we[i] && in_bundle_i.dst_areg[i] != '0;
                        if (wr) begin
                            spec_m[in_bundle_i.dst_areg[i]] = '{check: d.dst_check[i],
                                                                rob_id: d.dst_rob[i]};
                        end
                        issued_q.push_back('{rob_id: d.dst_rob[i], areg: in_bundle_i.dst_areg[i],
                                             we: in_bundle_i.dst_we[i],
                                             check: d.dst_check[i], data: '0});
                    end
                end
                head_m = head_m + rename_pkg::rob_id_t'(n_iss);
            end
            n_ret = int'(retire_valid_i[0]) + int'(retire_valid_i[1]);
            avail_m = occ_m <= `ROB_HIGH_WATER;
            occ_m = occ_m + n_iss - n_ret;
            valid_m = accept || (valid_m && !out_ready_i);
        end
    endtask

    // ret_mode 0 none, 1 random, 2 as fast as possible
    task automatic run_cycles(input int n, input logic valid, input logic oready,
                              input int ret_mode, input logic flush, input logic both);
        rename_pkg::decode_bundle_t b;
        for (int c = 0; c < n; c++) begin
            b = random_bundle();
            if (both) begin
                b.slot_valid = 2'b11;
            end
            in_valid_i = valid;
            in_bundle_i = b;
            out_ready_i = oready;
            flush_i = flush;
            retire_valid_i = '0;
            retire_i = '0;
            for (int k = 0; k < 2; k++) begin
                if (ret_mode != 0 && !flush && issued_q.size() > 0
                    && (k == 0 || retire_valid_i[0])
                    && (ret_mode == 2 || take_bits(1) == 32'd1)) begin
                    retire_i[k] = issued_q.pop_front();
                    retire_i[k].data = take_bits(32);
                    retire_valid_i[k] = 1'b1;
                end
            end
            @(negedge clk);
            #1;
            update_model();
            @(posedge clk);
            #1;
        end
    endtask

    always @(negedge clk) begin
        rename_pkg::dispatch_bundle_t e;
        if (out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("a bundle left the stage that was never accepted");
                $display("*** FAILED ***");
                $fatal(1);
            end else begin
                e = exp_q.pop_front();
                check_equal("pc", out_bundle_o.pc, e.pc);
                check_equal("slot_valid", out_bundle_o.slot_valid, e.slot_valid);
                check_equal("dst_areg", out_bundle_o.dst_areg, e.dst_areg);
                check_equal("dst_rob", out_bundle_o.dst_rob, e.dst_rob);
                check_equal("dst_check", out_bundle_o.dst_check, e.dst_check);
                check_equal("src_rob", out_bundle_o.src_rob, e.src_rob);
                check_equal("src_data", out_bundle_o.src_data, e.src_data);
                check_equal("src_ready", out_bundle_o.src_ready, e.src_ready);
                check_equal("use_imm", out_bundle_o.use_imm, e.use_imm);
                check_equal("imm", out_bundle_o.imm, e.imm);
            end
        end
        if (stall_q) begin
            check_equal("held bundle", {out_valid_o, out_bundle_o}, {1'b1, held_q});
        end
        stall_q = out_valid_o && !out_ready_i && !flush_i;
        held_q = out_bundle_o;
    end

    initial begin
        clk = 1'b0;
        arst_n_i = 1'b0;
        in_valid_i = 1'b0;
        in_bundle_i = '0;
        out_ready_i = 1'b0;
        retire_valid_i = '0;
        retire_i = '0;
        flush_i = 1'b0;
        reset_model();
        repeat (10) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        run_cycles(2, 1'b1, 1'b1, 0, 1'b0, 1'b1);
        run_cycles(20, 1'b1, 1'b1, 0, 1'b0, 1'b0);
        run_cycles(200, 1'b1, 1'b1, 1, 1'b0, 1'b0);
        // empty the ROB so the next bundle is surely taken and then held
        run_cycles(40, 1'b0, 1'b1, 2, 1'b0, 1'b0);
        // back-pressure
        run_cycles(1, 1'b1, 1'b1, 1, 1'b0, 1'b0);
        run_cycles(6, 1'b1, 1'b0, 0, 1'b0, 1'b0);
        run_cycles(4, 1'b1, 1'b1, 1, 1'b0, 1'b0);
        // fill past the high-water mark and then drain
        run_cycles(40, 1'b1, 1'b1, 0, 1'b0, 1'b1);
        run_cycles(40, 1'b0, 1'b1, 2, 1'b0, 1'b0);
        // flush with a bundle held at the output
        run_cycles(5, 1'b1, 1'b1, 1, 1'b0, 1'b0);
        run_cycles(1, 1'b1, 1'b0, 0, 1'b0, 1'b0);
        run_cycles(1, 1'b1, 1'b0, 0, 1'b1, 1'b0);
        run_cycles(5, 1'b1, 1'b1, 1, 1'b0, 1'b1);
        run_cycles(40, 1'b0, 1'b1, 2, 1'b0, 1'b0);
        if (exp_q.size() != 0) begin
            $display("%0d accepted bundles never left the stage", exp_q.size());
            $display("*** FAILED ***");
            $fatal(1);
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+src
src/rename_pkg.sv
src/spec_rat.sv
src/commit_rat.sv
src/arf.sv
src/rename_ctrl.sv
src/rename_unit.sv
verification/rename_unit_tb.sv
